// File: verilog/commit_pkg.sv
package commit_pkg;

    // one data or address word
    typedef logic [31:0] word_t;

    // architectural register index, r0 is hardwired to zero
    typedef logic [4:0] reg_idx_t;

    // operation carried by each slot into commit
    typedef enum logic [3:0]
    {
        OP_ALU    = 4'd0,
        OP_LB     = 4'd1,
        OP_LBU    = 4'd2,
        OP_LH     = 4'd3,
        OP_LHU    = 4'd4,
        OP_LW     = 4'd5,
        OP_SW     = 4'd6,
        OP_BRANCH = 4'd7,
        OP_JR     = 4'd8
    } commit_op_t;

    // two issue slots, slot 1 is the older one
    localparam int NUM_SLOTS = 2;

    // instruction size in bytes
    localparam word_t PC_STEP = 32'd4;

    // true for every op that reads data memory
    function automatic logic is_load(input commit_op_t op);
        logic res;
        case (op)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:
            begin
                res = 1'b1;
            end
            default:
            begin
                res = 1'b0;
            end
        endcase
        return res;
    endfunction

    // loads plus stores
    function automatic logic is_mem(input commit_op_t op);
        logic res;
        res = is_load(op) || (op == OP_SW);
        return res;
    endfunction

endpackage

// File: verilog/mem_rsp_if.sv
`timescale 1ns/1ps

// merged data memory response, hold side to load formatter
interface mem_rsp_if;
    import commit_pkg::*;

    // live read word when data_ok is high, held copy otherwise
    word_t      rsp_word;
    // memory access has finished for this pair
    logic       rsp_done;
    // byte offset within the word
    logic [1:0] addr_lo;
    // a memory request is outstanding
    logic       mem_en;

    modport hold
    (
        output rsp_word,
        output rsp_done,
        output addr_lo,
        output mem_en
    );

    modport fmt
    (
        input rsp_word,
        input addr_lo,
        input mem_en
    );

endinterface

// File: verilog/mem_resp_hold.sv
`timescale 1ns/1ps

module mem_resp_hold
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            dmem_en,
    input  logic            dmem_data_ok,
    input  commit_pkg::word_t dmem_rd,
    input  logic [1:0]      dmem_addr_lo,
    mem_rsp_if.hold         rsp
);
    import commit_pkg::*;

    // sticky data_ok and the word that came with it
    logic  ok_q;
    word_t word_q;

    // the pulse may arrive in any stalled cycle, so keep it until
    // the pipeline moves on
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ok_q   <= 1'b0;
            word_q <= '0;
        end
        else if (!stall)
        begin
            ok_q   <= 1'b0;
            word_q <= '0;
        end
        else if (dmem_data_ok)
        begin
            ok_q   <= 1'b1;
            word_q <= dmem_rd;
        end
    end

    // live word wins in the pulse cycle
    assign rsp.rsp_word = dmem_data_ok ? dmem_rd : word_q;

    // nothing to wait for when no request is out
    assign rsp.rsp_done = !dmem_en || dmem_data_ok || ok_q;

    assign rsp.addr_lo = dmem_addr_lo;
    assign rsp.mem_en  = dmem_en;

endmodule

// File: verilog/load_align.sv
`timescale 1ns/1ps

module load_align
(
    mem_rsp_if.fmt rsp,
    input  commit_pkg::commit_op_t [commit_pkg::NUM_SLOTS-1:0] slot_op,
    output commit_pkg::word_t                                  load_data
);
    import commit_pkg::*;

    commit_op_t  mem_op;
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    word_t       fmt_word;

    // at most one memory op per pair, slot 1 checked first
    assign mem_op = is_mem(slot_op[1]) ? slot_op[1] : slot_op[0];

    // little endian lanes
    assign byte_v = rsp.rsp_word[8*rsp.addr_lo +: 8];
    assign half_v = rsp.addr_lo[1] ? rsp.rsp_word[31:16] : rsp.rsp_word[15:0];

    always_comb
    begin
        case (mem_op)
            OP_LB:
            begin
                fmt_word = {{24{byte_v[7]}}, byte_v};
            end
            OP_LBU:
            begin
                fmt_word = {24'd0, byte_v};
            end
            OP_LH:
            begin
                fmt_word = {{16{half_v[15]}}, half_v};
            end
            OP_LHU:
            begin
                fmt_word = {16'd0, half_v};
            end
            default:
            begin
                fmt_word = rsp.rsp_word;
            end
        endcase
    end

    // no request out means no valid read data
    assign load_data = rsp.mem_en ? fmt_word : '0;

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve
(
    input  logic                   valid1,
    input  logic                   br_taken,
    input  logic                   pred_taken,
    input  commit_pkg::commit_op_t op1,
    input  commit_pkg::word_t      pc1,
    input  commit_pkg::word_t      br_target,
    input  commit_pkg::word_t      pred_target,
    input  commit_pkg::word_t      jr_src,
    output logic                   redirect_valid,
    output commit_pkg::word_t      redirect_pc,
    output logic                   bpb_wen,
    output commit_pkg::word_t      bpb_pc,
    output logic                   bpb_taken,
    output commit_pkg::word_t      bpb_target
);
    import commit_pkg::*;

    logic  is_br;
    logic  is_jr;
    logic  br_miss;
    logic  jr_miss;
    word_t fall_pc;

    assign is_br = valid1 && (op1 == OP_BRANCH);
    assign is_jr = valid1 && (op1 == OP_JR);

    // direction only, the target comes from execute
    assign br_miss = is_br && (br_taken != pred_taken);

    // jr also needs the predicted target to match the register value
    assign jr_miss = is_jr && (!pred_taken || (pred_target != jr_src));

    // skip over the delay slot
    assign fall_pc = pc1 + (PC_STEP << 1);

    assign redirect_valid = br_miss || jr_miss;
    assign redirect_pc    = is_jr ? jr_src : (br_taken ? br_target : fall_pc);

    // predictor learns from every resolved branch
    assign bpb_wen    = is_br;
    assign bpb_pc     = pc1;
    assign bpb_taken  = br_taken;
    assign bpb_target = br_target;

endmodule

// File: verilog/commit_select.sv
`timescale 1ns/1ps

module commit_select
(
    input  logic [commit_pkg::NUM_SLOTS-1:0]                   slot_valid,
    input  logic [commit_pkg::NUM_SLOTS-1:0]                   slot_regwrite,
    input  commit_pkg::commit_op_t [commit_pkg::NUM_SLOTS-1:0] slot_op,
    input  commit_pkg::reg_idx_t [commit_pkg::NUM_SLOTS-1:0]   slot_dest,
    input  commit_pkg::word_t [commit_pkg::NUM_SLOTS-1:0]      slot_result,
    input  commit_pkg::word_t                                  load_data,
    input  logic                                               finish,
    output logic [commit_pkg::NUM_SLOTS-1:0]                   wb_wen,
    output commit_pkg::reg_idx_t [commit_pkg::NUM_SLOTS-1:0]   wb_dest,
    output commit_pkg::word_t [commit_pkg::NUM_SLOTS-1:0]      wb_data
);
    import commit_pkg::*;

    logic [NUM_SLOTS-1:0] slot_load;

    always_comb
    begin
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            slot_load[i] = is_load(slot_op[i]);

            // the formatted word only goes to the load slot
            wb_data[i] = slot_load[i] ? load_data : slot_result[i];
            wb_dest[i] = slot_dest[i];

            // r0 writes are dropped, loads wait for memory
            wb_wen[i] = slot_valid[i] && slot_regwrite[i]
                        && (slot_dest[i] != '0)
                        && (!slot_load[i] || finish);
        end
    end

endmodule

// File: verilog/commit_stage.sv
`timescale 1ns/1ps

module commit_stage
(
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  logic                                               stall,
    input  logic [commit_pkg::NUM_SLOTS-1:0]                   slot_valid,
    input  commit_pkg::commit_op_t [commit_pkg::NUM_SLOTS-1:0] slot_op,
    input  commit_pkg::word_t [commit_pkg::NUM_SLOTS-1:0]      slot_pc,
    input  commit_pkg::word_t [commit_pkg::NUM_SLOTS-1:0]      slot_result,
    input  commit_pkg::reg_idx_t [commit_pkg::NUM_SLOTS-1:0]   slot_dest,
    input  logic [commit_pkg::NUM_SLOTS-1:0]                   slot_regwrite,
    input  logic                                               br_taken,
    input  commit_pkg::word_t                                  br_target,
    input  logic                                               pred_taken,
    input  commit_pkg::word_t                                  pred_target,
    input  logic                                               dmem_en,
    input  commit_pkg::word_t                                  dmem_addr,
    input  commit_pkg::word_t                                  dmem_rd,
    input  logic                                               dmem_data_ok,
    output logic                                               finish,
    output logic [commit_pkg::NUM_SLOTS-1:0]                   wb_wen,
    output commit_pkg::reg_idx_t [commit_pkg::NUM_SLOTS-1:0]   wb_dest,
    output commit_pkg::word_t [commit_pkg::NUM_SLOTS-1:0]      wb_data,
    output logic                                               redirect_valid,
    output commit_pkg::word_t                                  redirect_pc,
    output logic                                               bpb_wen,
    output commit_pkg::word_t                                  bpb_pc,
    output logic                                               bpb_taken,
    output commit_pkg::word_t                                  bpb_target
);
    import commit_pkg::*;

    mem_rsp_if rsp();

    word_t load_data;

    mem_resp_hold u_hold
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .dmem_en      (dmem_en),
        .dmem_data_ok (dmem_data_ok),
        .dmem_rd      (dmem_rd),
        .dmem_addr_lo (dmem_addr[1:0]),
        .rsp          (rsp)
    );

    assign finish = rsp.rsp_done;

    load_align u_align
    (
        .rsp       (rsp),
        .slot_op   (slot_op),
        .load_data (load_data)
    );

    // only slot 1 may carry control flow
    branch_resolve u_branch
    (
        .valid1         (slot_valid[1]),
        .br_taken       (br_taken),
        .pred_taken     (pred_taken),
        .op1            (slot_op[1]),
        .pc1            (slot_pc[1]),
        .br_target      (br_target),
        .pred_target    (pred_target),
        .jr_src         (slot_result[1]),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .bpb_wen        (bpb_wen),
        .bpb_pc         (bpb_pc),
        .bpb_taken      (bpb_taken),
        .bpb_target     (bpb_target)
    );

    commit_select u_select
    (
        .slot_valid    (slot_valid),
        .slot_regwrite (slot_regwrite),
        .slot_op       (slot_op),
        .slot_dest     (slot_dest),
        .slot_result   (slot_result),
        .load_data     (load_data),
        .finish        (finish),
        .wb_wen        (wb_wen),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic arst_n
);
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // release away from the active edge
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD_NS / 4);
        arst_n = 1'b1;
    end

endmodule

// File: tb/commit_stage_tb.sv
`timescale 1ns/1ps

module commit_stage_tb;
    import commit_pkg::*;

    logic                  clk, arst_n, stall, dmem_en, dmem_data_ok;
    logic [1:0]            slot_valid, slot_regwrite, wb_wen;
    commit_op_t [1:0]      slot_op;
    word_t [1:0]           slot_pc, slot_result, wb_data;
    reg_idx_t [1:0]        slot_dest, wb_dest;
    logic                  br_taken, pred_taken, finish, redirect_valid, bpb_wen, bpb_taken;
    word_t                 br_target, pred_target, dmem_addr, dmem_rd;
    word_t                 redirect_pc, bpb_pc, bpb_target;

    // reference model state and expected outputs
    logic                  ref_ok, exp_finish, is_br, is_jr, exp_redirect;
    word_t                 ref_word, ref_rsp, exp_redirect_pc;
    commit_op_t            mem_op;
    logic [1:0]            exp_wen;
    logic [63:0]           exp_data, data_mask;
    logic [64:0]           exp_bpb, act_bpb;
    logic [15:0]           lfsr;
    int                    check_errs, timeout_errs;
    commit_op_t            load_ops [5] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (.*);

    commit_stage u_dut (.*);

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic is_load_op(input commit_op_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    // little endian lane pick followed by extension
    function automatic word_t format_load(input commit_op_t op, input word_t w,
                                          input logic [1:0] lo);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       r;
        b = 8'(w >> {lo, 3'b000});
        h = lo[1] ? w[31:16] : w[15:0];
        case (op)
            OP_LB:   r = 32'($signed(b));
            OP_LBU:  r = 32'(b);
            OP_LH:   r = 32'($signed(h));
            OP_LHU:  r = 32'(h);
            default: r = w;
        endcase
        return r;
    endfunction

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n || !stall)
        begin
            ref_ok   <= 1'b0;
            ref_word <= '0;
        end
        else if (dmem_data_ok)
        begin
            ref_ok   <= 1'b1;
            ref_word <= dmem_rd;
        end
    end

    always_comb
    begin
        ref_rsp    = dmem_data_ok ? dmem_rd : ref_word;
        exp_finish = !dmem_en || dmem_data_ok || ref_ok;
        mem_op     = (is_load_op(slot_op[1]) || slot_op[1] == OP_SW) ? slot_op[1] : slot_op[0];
        for (int i = 0; i < 2; i++)
        begin
            exp_wen[i] = slot_valid[i] && slot_regwrite[i] && (slot_dest[i] != 5'd0)
                         && (!is_load_op(slot_op[i]) || exp_finish);
            exp_data[32*i +: 32] = is_load_op(slot_op[i])
                                   ? format_load(mem_op, ref_rsp, dmem_addr[1:0])
                                   : slot_result[i];
            // load data only defined while a request is out
            data_mask[32*i +: 32] = {32{exp_wen[i] && (dmem_en || !is_load_op(slot_op[i]))}};
        end
        is_br = slot_valid[1] && (slot_op[1] == OP_BRANCH);
        is_jr = slot_valid[1] && (slot_op[1] == OP_JR);
        exp_redirect = (is_br && (br_taken != pred_taken))
                       || (is_jr && (!pred_taken || (pred_target != slot_result[1])));
        exp_redirect_pc = is_jr ? slot_result[1]
                        : (br_taken ? br_target : slot_pc[1] + 2 * PC_STEP);
        exp_bpb = {slot_pc[1], br_taken, br_target};
        act_bpb = {bpb_pc, bpb_taken, bpb_target};
    end

    task automatic report_mismatch(input string name, input logic [95:0] exp_v,
                                   input logic [95:0] act_v);
        check_errs++;
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    endtask

    a_finish: assert property (@(posedge clk) finish == exp_finish)
        else report_mismatch("finish", 96'($sampled(exp_finish)), 96'($sampled(finish)));
    a_wen: assert property (@(posedge clk) wb_wen == exp_wen)
        else report_mismatch("wb_wen", 96'($sampled(exp_wen)), 96'($sampled(wb_wen)));
    a_dest: assert property (@(posedge clk) wb_dest == slot_dest)
        else report_mismatch("wb_dest", 96'($sampled(slot_dest)), 96'($sampled(wb_dest)));
    a_data: assert property (@(posedge clk) (wb_data & data_mask) == (exp_data & data_mask))
        else report_mismatch("wb_data", 96'($sampled(exp_data & data_mask)),
                             96'($sampled(wb_data & data_mask)));
    a_redir: assert property (@(posedge clk) redirect_valid == exp_redirect)
        else report_mismatch("redirect_valid", 96'($sampled(exp_redirect)),
                             96'($sampled(redirect_valid)));
    a_redir_pc: assert property (@(posedge clk) !exp_redirect || redirect_pc == exp_redirect_pc)
        else report_mismatch("redirect_pc", 96'($sampled(exp_redirect_pc)),
                             96'($sampled(redirect_pc)));
    a_bpb_wen: assert property (@(posedge clk) bpb_wen == is_br)
        else report_mismatch("bpb_wen", 96'($sampled(is_br)), 96'($sampled(bpb_wen)));
    a_bpb: assert property (@(posedge clk) !is_br || act_bpb == exp_bpb)
        else report_mismatch("bpb_pc/taken/target", 96'($sampled(exp_bpb)),
                             96'($sampled(act_bpb)));

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        stall         = 1'b0;
        slot_valid    = '0;
        slot_op[0]    = OP_ALU;
        slot_op[1]    = OP_ALU;
        slot_pc       = '0;
        slot_result   = '0;
        slot_dest     = '0;
        slot_regwrite = '0;
        br_taken      = 1'b0;
        br_target     = '0;
        pred_taken    = 1'b0;
        pred_target   = '0;
        dmem_en       = 1'b0;
        dmem_addr     = '0;
        dmem_rd       = '0;
        dmem_data_ok  = 1'b0;
    endtask

    task automatic drive_alu_pair(input logic zero_dest);
        for (int i = 0; i < 2; i++)
        begin
            slot_op[i]     = OP_ALU;
            slot_pc[i]     = rand_bits(32) & ~32'h3;
            slot_result[i] = rand_bits(32);
            slot_dest[i]   = 5'(rand_bits(5));
        end
        slot_valid    = 2'(rand_bits(2));
        slot_regwrite = 2'(rand_bits(2));
        if (zero_dest)
        begin
            slot_dest[1'(rand_bits(1))] = '0;
        end
    endtask

    // load in a random slot while the other slot stays alu
    task automatic drive_load_pair(input commit_op_t op);
        logic s;
        drive_alu_pair(1'b0);
        s                = 1'(rand_bits(1));
        slot_op[s]       = op;
        slot_valid[s]    = 1'b1;
        slot_regwrite[s] = 1'b1;
        slot_dest[s]     = 5'(rand_bits(4)) + 5'd1;
        dmem_en          = 1'b1;
        dmem_addr        = rand_bits(32);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < 40)
        begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1)
        begin
            $display("timeout: reset still asserted after %0d cycles", n);
            timeout_errs++;
        end
    endtask

    task automatic wait_finish(input int limit);
        int n;
        n = 0;
        #1;
        while (finish !== 1'b1 && n < limit)
        begin
            next_cycle();
            #1;
            n++;
        end
        if (finish !== 1'b1)
        begin
            $display("timeout: finish stayed low for %0d cycles after data_ok", n);
            timeout_errs++;
        end
    endtask

    initial
    begin
        int delay;
        check_errs   = 0;
        timeout_errs = 0;
        lfsr         = 16'd93;
        drive_idle();
        wait_reset_release();
        repeat (3) next_cycle();

        // alu pairs with an r0 destination in every fourth one
        for (int i = 0; i < 40; i++)
        begin
            next_cycle();
            drive_alu_pair(i % 4 == 0);
        end

        // loads answered in the request cycle
        for (int i = 0; i < 50; i++)
        begin
            next_cycle();
            drive_load_pair(load_ops[i % 5]);
            stall        = 1'(rand_bits(1));
            dmem_rd      = rand_bits(32);
            dmem_data_ok = 1'b1;
            wait_finish(4);
        end

        // late response while the read bus keeps moving
        for (int i = 0; i < 10; i++)
        begin
            next_cycle();
            drive_idle();
            next_cycle();
            drive_load_pair(load_ops[i % 5]);
            stall   = 1'b1;
            dmem_rd = rand_bits(32);
            delay   = 1 + int'(rand_bits(3) % 5);
            repeat (delay)
            begin
                next_cycle();
                dmem_rd = rand_bits(32);
            end
            dmem_data_ok = 1'b1;
            wait_finish(3);
            repeat (3)
            begin
                next_cycle();
                dmem_data_ok = 1'b0;
                dmem_rd      = rand_bits(32);
            end
            next_cycle();
            stall = 1'b0;
            next_cycle();
            drive_load_pair(load_ops[(i + 2) % 5]);
            stall   = 1'b1;
            dmem_rd = rand_bits(32);
            next_cycle();
            dmem_data_ok = 1'b1;
            wait_finish(3);
        end

        // all taken and predicted combinations with the last one not valid
        for (int i = 0; i < 16; i++)
        begin
            next_cycle();
            drive_idle();
            drive_alu_pair(1'b0);
            slot_op[1]    = OP_BRANCH;
            slot_valid[1] = (i != 15);
            br_taken      = i[0];
            pred_taken    = i[1];
            br_target     = rand_bits(32);
            pred_target   = rand_bits(32);
        end

        // jr with matching and wrong predicted target
        for (int i = 0; i < 12; i++)
        begin
            next_cycle();
            drive_alu_pair(1'b0);
            slot_op[1]    = OP_JR;
            slot_valid[1] = 1'b1;
            pred_taken    = i[0];
            br_taken      = 1'(rand_bits(1));
            pred_target   = i[1] ? slot_result[1] : slot_result[1] ^ 32'h40;
        end

        next_cycle();
        drive_idle();
        repeat (2) next_cycle();
        $display("errors: %0d check, %0d timeout", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: commit_stage.f
verilog/commit_pkg.sv
verilog/mem_rsp_if.sv
verilog/mem_resp_hold.sv
verilog/load_align.sv
verilog/branch_resolve.sv
verilog/commit_select.sv
verilog/commit_stage.sv
tb/tb_clock.sv
tb/commit_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the commit stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module commit_stage_tb \
    -f commit_stage.f \
    -o commit_stage_sim

./obj_dir/commit_stage_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
